/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f tb.f --top-module rv_core_tb -o rv_core_sim
./obj_dir/rv_core_sim | tee sim.log
if grep -qx "NO ERRORS" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1

/* tb.f */
verilog/rv_isa_pkg.sv
verilog/rv_core_pkg.sv
verilog/rv_idu.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_lsu.sv
verilog/rv_exu.sv
verilog/rv_core_top.sv
verif/rv_exu_checker.sv
verif/rv_core_tb.sv

/* verif/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;

  localparam int opc_load   = 'h03;
  localparam int opc_imm    = 'h13;
  localparam int opc_imm_32 = 'h1b;
  localparam int opc_reg    = 'h33;
  localparam int opc_reg_32 = 'h3b;
  localparam int opc_lui    = 'h37;
  localparam int opc_auipc  = 'h17;
  localparam int opc_jalr   = 'h67;
  localparam logic [31:0] nop    = 32'h0000_0013;
  localparam logic [31:0] ebreak = 32'h0010_0073;

  logic        clk = 1'b0;
  logic        rst_n;
  logic [31:0] inst;
  logic [63:0] pc;
  logic        wb_en;
  logic [4:0]  wb_rd;
  logic [63:0] wb_data;
  logic        halted;
  logic        halt_code;

  // program table with one entry per instruction
  string       t_name[$];
  logic [31:0] t_inst[$];
  bit          t_en[$];
  logic [4:0]  t_rd[$];
  logic [63:0] t_data[$];
  logic [63:0] t_pc[$];

  logic [63:0] cur_pc;
  int          errors;
  int          step_errors;
  int          passed;
  int          failed;
  int          waited;

  rv_core_top #(
    .dmem_words (256)
  ) i_rv_core_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .inst      (inst),
    .pc        (pc),
    .wb_en     (wb_en),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data),
    .halted    (halted),
    .halt_code (halt_code)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] r_type(int f7, int rs2, int rs1, int f3, int rd, int opc);
    r_type = {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] i_type(int imm, int rs1, int f3, int rd, int opc);
    i_type = {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] s_type(int imm, int rs2, int rs1, int f3);
    s_type = {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] b_type(int imm, int rs2, int rs1, int f3);
    b_type = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] u_type(int imm, int rd, int opc);
    u_type = {imm[19:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] j_type(int imm, int rd);
    j_type = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
  endfunction

  // delta is the pc change that this instruction causes
  task automatic add_step(string name, logic [31:0] word, bit en, int rd,
                          logic [63:0] data, longint delta);
    t_name.push_back(name);
    t_inst.push_back(word);
    t_en.push_back(en);
    t_rd.push_back(rd[4:0]);
    t_data.push_back(data);
    cur_pc = cur_pc + delta;
    t_pc.push_back(cur_pc);
  endtask

  task automatic compare_value(string sig, logic [63:0] exp, logic [63:0] act);
    if (act !== exp) begin
      $display("mismatch at %0t: %s expected %h got %h", $time, sig, exp, act);
      errors++;
      step_errors++;
    end
  endtask

  task automatic report_step(string name);
    if (step_errors == 0) begin
      passed++;
      $display("ok    %s", name);
    end else begin
      failed++;
      $display("fail  %s", name);
    end
  endtask

  initial begin
    rst_n  = 1'b0;
    inst   = nop;
    cur_pc = 64'h0000_0000_8000_0000;
    errors = 0;
    passed = 0;
    failed = 0;

    add_step("addi x1", i_type(5, 0, 0, 1, opc_imm), 1, 1, 64'd5, 4);
    add_step("addi x2", i_type(-3, 0, 0, 2, opc_imm), 1, 2, 64'hffff_ffff_ffff_fffd, 4);
    add_step("add", r_type(0, 2, 1, 0, 3, opc_reg), 1, 3, 64'd2, 4);
    add_step("sub", r_type('h20, 1, 2, 0, 4, opc_reg), 1, 4, 64'hffff_ffff_ffff_fff8, 4);
    add_step("lui neg", u_type('h80000, 6, opc_lui), 1, 6, 64'hffff_ffff_8000_0000, 4);
    add_step("sra", r_type('h20, 1, 6, 5, 7, opc_reg), 1, 7, 64'hffff_ffff_fc00_0000, 4);
    add_step("srl", r_type(0, 1, 6, 5, 8, opc_reg), 1, 8, 64'h07ff_ffff_fc00_0000, 4);
    add_step("sll", r_type(0, 1, 1, 1, 9, opc_reg), 1, 9, 64'h0000_0000_0000_00a0, 4);
    add_step("or", r_type(0, 1, 4, 6, 11, opc_reg), 1, 11, 64'hffff_ffff_ffff_fffd, 4);
    add_step("xor", r_type(0, 1, 2, 4, 12, opc_reg), 1, 12, 64'hffff_ffff_ffff_fff8, 4);
    add_step("and", r_type(0, 1, 2, 7, 13, opc_reg), 1, 13, 64'd5, 4);
    add_step("slt", r_type(0, 1, 4, 2, 14, opc_reg), 1, 14, 64'd1, 4);
    add_step("sltu", r_type(0, 1, 4, 3, 15, opc_reg), 1, 15, 64'd0, 4);
    add_step("slti", i_type(-1, 1, 2, 16, opc_imm), 1, 16, 64'd0, 4);
    add_step("sltiu", i_type(-1, 1, 3, 17, opc_imm), 1, 17, 64'd1, 4);
    add_step("andi", i_type('hf0, 2, 7, 18, opc_imm), 1, 18, 64'h0000_0000_0000_00f0, 4);
    add_step("ori", i_type('h100, 1, 6, 19, opc_imm), 1, 19, 64'h0000_0000_0000_0105, 4);
    add_step("xori", i_type(-1, 1, 4, 20, opc_imm), 1, 20, 64'hffff_ffff_ffff_fffa, 4);
    add_step("slli", i_type(40, 1, 1, 21, opc_imm), 1, 21, 64'h0000_0500_0000_0000, 4);
    add_step("srli", i_type(32, 6, 5, 22, opc_imm), 1, 22, 64'h0000_0000_ffff_ffff, 4);
    add_step("srai", i_type('h400 | 20, 6, 5, 23, opc_imm), 1, 23, 64'hffff_ffff_ffff_f800, 4);
    add_step("addi x0", i_type(7, 1, 0, 0, opc_imm), 0, 0, 64'd0, 4);

    // word ops on both sides of bit 31
    add_step("lui pos", u_type('h7ffff, 24, opc_lui), 1, 24, 64'h0000_0000_7fff_f000, 4);
    add_step("addiw", i_type('h7ff, 24, 0, 25, opc_imm_32), 1, 25, 64'h0000_0000_7fff_f7ff, 4);
    add_step("addw", r_type(0, 24, 24, 0, 26, opc_reg_32), 1, 26, 64'hffff_ffff_ffff_e000, 4);
    add_step("subw pos", r_type('h20, 4, 1, 0, 27, opc_reg_32), 1, 27, 64'd13, 4);
    add_step("subw neg", r_type('h20, 24, 2, 0, 28, opc_reg_32), 1, 28, 64'hffff_ffff_8000_0ffd, 4);
    add_step("sllw", r_type(0, 1, 24, 1, 29, opc_reg_32), 1, 29, 64'hffff_ffff_fffe_0000, 4);
    add_step("sllw 5 bit", r_type(0, 9, 1, 1, 30, opc_reg_32), 1, 30, 64'd5, 4);

    // doubleword at 0x100 with narrower lanes merged into it
    add_step("sd", s_type('h100, 8, 0, 3), 0, 0, 64'd0, 4);
    add_step("sw", s_type('h104, 13, 0, 2), 0, 0, 64'd0, 4);
    add_step("sh", s_type('h102, 20, 0, 1), 0, 0, 64'd0, 4);
    add_step("sb hi", s_type('h101, 9, 0, 0), 0, 0, 64'd0, 4);
    add_step("sb lo", s_type('h100, 19, 0, 0), 0, 0, 64'd0, 4);
    add_step("ld", i_type('h100, 0, 3, 5, opc_load), 1, 5, 64'h0000_0005_fffa_a005, 4);
    add_step("lw lo", i_type('h100, 0, 2, 7, opc_load), 1, 7, 64'hffff_ffff_fffa_a005, 4);
    add_step("lw hi", i_type('h104, 0, 2, 8, opc_load), 1, 8, 64'd5, 4);
    add_step("lb", i_type('h101, 0, 0, 11, opc_load), 1, 11, 64'hffff_ffff_ffff_ffa0, 4);
    add_step("lbu", i_type('hfc, 1, 4, 12, opc_load), 1, 12, 64'h0000_0000_0000_00a0, 4);

    add_step("beq taken", b_type(8, 13, 1, 0), 0, 0, 64'd0, 8);
    add_step("beq not", b_type(8, 2, 1, 0), 0, 0, 64'd0, 4);
    add_step("bne taken", b_type(12, 2, 1, 1), 0, 0, 64'd0, 12);
    add_step("bne not", b_type(8, 13, 1, 1), 0, 0, 64'd0, 4);
    add_step("blt taken", b_type(-16, 1, 4, 4), 0, 0, 64'd0, -16);
    add_step("blt not", b_type(8, 4, 1, 4), 0, 0, 64'd0, 4);
    add_step("bge taken", b_type(20, 2, 1, 5), 0, 0, 64'd0, 20);
    add_step("bge not", b_type(8, 2, 4, 5), 0, 0, 64'd0, 4);
    add_step("jal", j_type(256, 17), 1, 17, cur_pc + 64'd4, 256);
    add_step("jal back", j_type(-2048, 18), 1, 18, cur_pc + 64'd4, -2048);
    add_step("auipc", u_type('h12345, 19, opc_auipc), 1, 19, cur_pc + 64'h1234_5000, 4);
    add_step("auipc 0", u_type(0, 15, opc_auipc), 1, 15, cur_pc, 4);
    // odd target x15+21 loses bit 0 and lands 16 past the jalr
    add_step("jalr", i_type(21, 15, 0, 16, opc_jalr), 1, 16, cur_pc + 64'd4, 16);

    add_step("a0 = 1", i_type(1, 0, 0, 10, opc_imm), 1, 10, 64'd1, 4);
    add_step("ebreak", ebreak, 0, 0, 64'd0, 0);
    add_step("addi halted", i_type(9, 0, 0, 5, opc_imm), 0, 0, 64'd0, 0);
    add_step("jal halted", j_type(8, 1), 0, 0, 64'd0, 0);

    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    inst  <= t_inst[0];

    @(negedge clk);
    step_errors = 0;
    compare_value("pc", 64'h0000_0000_8000_0000, pc);
    compare_value("halted", 64'd0, {63'd0, halted});
    report_step("reset");

    for (int i = 0; i < t_inst.size(); i++) begin
      step_errors = 0;
      compare_value("wb_en", {63'd0, t_en[i]}, {63'd0, wb_en});
      if (t_en[i]) begin
        compare_value("wb_rd", {59'd0, t_rd[i]}, {59'd0, wb_rd});
        compare_value("wb_data", t_data[i], wb_data);
      end
      @(posedge clk);
      if (i + 1 < t_inst.size()) begin
        inst <= t_inst[i + 1];
      end else begin
        inst <= nop;
      end
      #1;
      compare_value("pc", t_pc[i], pc);
      report_step(t_name[i]);
      @(negedge clk);
    end

    step_errors = 0;
    waited = 0;
    while (halted !== 1'b1 && waited < 20) begin
      @(posedge clk);
      waited++;
    end
    if (halted !== 1'b1) begin
      $display("the core never halted within 20 cycles after ebreak");
      errors++;
      step_errors++;
    end else begin
      compare_value("halt_code", 64'd1, {63'd0, halt_code});
    end
    report_step("halt");

    $display("summary: %0d tests passed, %0d failed, %0d errors", passed, failed, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* verif/rv_exu_checker.sv */
`timescale 1ns/1ps

module rv_exu_checker (
  input logic                         clk,
  input logic                         rst_n,
  input logic [rv_core_pkg::xlen-1:0] x0_value,
  input logic [rv_core_pkg::xlen-1:0] pc,
  input logic                         halted,
  input logic                         wb_en,
  input logic [4:0]                   wb_rd
);

  // storage behind x0 keeps whatever it held from power-up
  x0_never_written: assert property (@(posedge clk) disable iff (!rst_n)
    $stable(x0_value))
    else $error("register file entry for x0 changed");

  pc_held_while_halted: assert property (@(posedge clk) disable iff (!rst_n)
    halted |=> $stable(pc))
    else $error("pc moved while the core was halted");

  no_commit_to_x0: assert property (@(posedge clk) disable iff (!rst_n)
    wb_en |-> (wb_rd != 5'd0))
    else $error("wb_en high with wb_rd equal to x0");

endmodule

bind rv_exu rv_exu_checker i_rv_exu_checker (
  .clk      (clk),
  .rst_n    (rst_n),
  .x0_value (i_rv_regfile.regs[0]),
  .pc       (pc),
  .halted   (halted),
  .wb_en    (wb_en),
  .wb_rd    (wb_rd)
);

/* verilog/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu (
  input  rv_core_pkg::alu_mode_e       mode,
  input  logic [rv_core_pkg::xlen-1:0] operand_a,
  input  logic [rv_core_pkg::xlen-1:0] operand_b,
  output logic [rv_core_pkg::xlen-1:0] result
);

  import rv_core_pkg::*;

  logic [5:0] sh;

  assign sh = operand_b[5:0];

  always_comb begin
    case (mode)
      alu_add:  result = operand_a + operand_b;
      alu_sub:  result = operand_a - operand_b;
      alu_and:  result = operand_a & operand_b;
      alu_or:   result = operand_a | operand_b;
      alu_xor:  result = operand_a ^ operand_b;
      alu_sll:  result = operand_a << sh;
      alu_srl:  result = operand_a >> sh;
      alu_sra:  result = $signed(operand_a) >>> sh;
      alu_slt:  result = {{(xlen-1){1'b0}}, $signed(operand_a) < $signed(operand_b)};
      alu_sltu: result = {{(xlen-1){1'b0}}, operand_a < operand_b};
      default:  result = operand_a + operand_b;
    endcase
  end

endmodule

/* verilog/rv_core_pkg.sv */
package rv_core_pkg;

  localparam int xlen = 64;

  localparam logic [xlen-1:0] reset_pc = 64'h0000_0000_8000_0000;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu
  } alu_mode_e;

endpackage

/* verilog/rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top #(
  parameter int dmem_words = 256
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [31:0]                  inst,
  output logic [rv_core_pkg::xlen-1:0] pc,
  output logic                         wb_en,
  output logic [4:0]                   wb_rd,
  output logic [rv_core_pkg::xlen-1:0] wb_data,
  output logic                         halted,
  output logic                         halt_code
);

  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  op_e             op;
  logic [4:0]      rd;
  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;
  logic [5:0]      shamt;

  rv_idu i_rv_idu (
    .inst  (inst),
    .op    (op),
    .rd    (rd),
    .rs1   (rs1),
    .rs2   (rs2),
    .imm_i (imm_i),
    .imm_s (imm_s),
    .imm_b (imm_b),
    .imm_u (imm_u),
    .imm_j (imm_j),
    .shamt (shamt)
  );

  rv_exu #(
    .dmem_words (dmem_words)
  ) i_rv_exu (
    .clk       (clk),
    .rst_n     (rst_n),
    .op        (op),
    .rd        (rd),
    .rs1       (rs1),
    .rs2       (rs2),
    .imm_i     (imm_i),
    .imm_s     (imm_s),
    .imm_b     (imm_b),
    .imm_u     (imm_u),
    .imm_j     (imm_j),
    .shamt     (shamt),
    .pc        (pc),
    .wb_en     (wb_en),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data),
    .halted    (halted),
    .halt_code (halt_code)
  );

endmodule

/* verilog/rv_exu.sv */
`timescale 1ns/1ps

module rv_exu #(
  parameter int dmem_words = 256
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  rv_isa_pkg::op_e              op,
  input  logic [4:0]                   rd,
  input  logic [4:0]                   rs1,
  input  logic [4:0]                   rs2,
  input  logic [rv_core_pkg::xlen-1:0] imm_i,
  input  logic [rv_core_pkg::xlen-1:0] imm_s,
  input  logic [rv_core_pkg::xlen-1:0] imm_b,
  input  logic [rv_core_pkg::xlen-1:0] imm_u,
  input  logic [rv_core_pkg::xlen-1:0] imm_j,
  input  logic [5:0]                   shamt,
  output logic [rv_core_pkg::xlen-1:0] pc,
  output logic                         wb_en,
  output logic [4:0]                   wb_rd,
  output logic [rv_core_pkg::xlen-1:0] wb_data,
  output logic                         halted,
  output logic                         halt_code
);

  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  logic [4:0]      rf_raddr_a;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  alu_mode_e       alu_mode;
  logic [xlen-1:0] alu_a;
  logic [xlen-1:0] alu_b;
  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] load_data;
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] next_pc;
  logic            br_taken;
  logic            rd_write;
  logic            is_store;
  logic            store_en;

  // ebreak has rs1 = x0, so port a looks at a0 for the exit code
  assign rf_raddr_a = (op == op_i_ebreak) ? 5'd10 : rs1;

  rv_regfile i_rv_regfile (
    .clk     (clk),
    .wen     (wb_en),
    .waddr   (rd),
    .wdata   (wb_data),
    .raddr_a (rf_raddr_a),
    .raddr_b (rs2),
    .rdata_a (rs1_data),
    .rdata_b (rs2_data)
  );

  always_comb begin
    case (op)
      op_i_sub, op_i_subw:              alu_mode = alu_sub;
      op_i_and, op_i_andi:              alu_mode = alu_and;
      op_i_or, op_i_ori:                alu_mode = alu_or;
      op_i_xor, op_i_xori:              alu_mode = alu_xor;
      op_i_sll, op_i_slli, op_i_sllw:   alu_mode = alu_sll;
      op_i_srl, op_i_srli:              alu_mode = alu_srl;
      op_i_sra, op_i_srai:              alu_mode = alu_sra;
      op_i_slt, op_i_slti:              alu_mode = alu_slt;
      op_i_sltu, op_i_sltiu:            alu_mode = alu_sltu;
      default:                          alu_mode = alu_add;
    endcase
  end

  assign alu_a = (op == op_i_auipc) ? pc : rs1_data;

  always_comb begin
    case (op)
      op_i_add, op_i_sub, op_i_and, op_i_or, op_i_xor,
      op_i_sll, op_i_srl, op_i_sra, op_i_slt, op_i_sltu,
      op_i_addw, op_i_subw:              alu_b = rs2_data;
      op_i_slli, op_i_srli, op_i_srai:   alu_b = {{(xlen-6){1'b0}}, shamt};
      // sllw only shifts by 0..31
      op_i_sllw:                         alu_b = {{(xlen-5){1'b0}}, rs2_data[4:0]};
      op_i_auipc:                        alu_b = imm_u;
      op_i_sb, op_i_sh, op_i_sw, op_i_sd: alu_b = imm_s;
      default:                           alu_b = imm_i;
    endcase
  end

  rv_alu i_rv_alu (
    .mode      (alu_mode),
    .operand_a (alu_a),
    .operand_b (alu_b),
    .result    (alu_result)
  );

  assign is_store = (op == op_i_sb) || (op == op_i_sh) || (op == op_i_sw) || (op == op_i_sd);
  assign store_en = is_store && !halted;

  rv_lsu #(
    .dmem_words (dmem_words)
  ) i_rv_lsu (
    .clk        (clk),
    .rst_n      (rst_n),
    .op         (op),
    .wen        (store_en),
    .addr       (alu_result),
    .store_data (rs2_data),
    .load_data  (load_data)
  );

  always_comb begin
    case (op)
      op_i_beq: br_taken = (rs1_data == rs2_data);
      op_i_bne: br_taken = (rs1_data != rs2_data);
      op_i_blt: br_taken = ($signed(rs1_data) < $signed(rs2_data));
      op_i_bge: br_taken = ($signed(rs1_data) >= $signed(rs2_data));
      default:  br_taken = 1'b0;
    endcase
  end

  assign pc_plus4 = pc + 'd4;

  always_comb begin
    case (op)
      op_i_jal:    next_pc = pc + imm_j;
      op_i_jalr:   next_pc = {alu_result[xlen-1:1], 1'b0};
      op_i_ebreak: next_pc = pc;
      default:     next_pc = br_taken ? (pc + imm_b) : pc_plus4;
    endcase
  end

  // write-back select
  always_comb begin
    rd_write = 1'b1;
    wb_data  = alu_result;
    case (op)
      op_i_addw, op_i_subw, op_i_addiw, op_i_sllw:
        wb_data = {{(xlen-32){alu_result[31]}}, alu_result[31:0]};
      op_i_lui:                          wb_data = imm_u;
      op_i_jal, op_i_jalr:               wb_data = pc_plus4;
      op_i_lb, op_i_lbu, op_i_lw, op_i_ld: wb_data = load_data;
      op_illegal, op_i_ebreak,
      op_i_beq, op_i_bne, op_i_blt, op_i_bge,
      op_i_sb, op_i_sh, op_i_sw, op_i_sd: rd_write = 1'b0;
      default:                           wb_data = alu_result;
    endcase
  end

  assign wb_en = rst_n && !halted && rd_write && (rd != 5'd0);
  assign wb_rd = rd;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc        <= reset_pc;
      halted    <= 1'b0;
      halt_code <= 1'b0;
    end else if (!halted) begin
      pc <= next_pc;
      if (op == op_i_ebreak) begin
        halted    <= 1'b1;
        halt_code <= (rs1_data != '0);
      end
    end
  end

endmodule

/* verilog/rv_idu.sv */
`timescale 1ns/1ps

module rv_idu (
  input  logic [31:0]                  inst,
  output rv_isa_pkg::op_e              op,
  output logic [4:0]                   rd,
  output logic [4:0]                   rs1,
  output logic [4:0]                   rs2,
  output logic [rv_core_pkg::xlen-1:0] imm_i,
  output logic [rv_core_pkg::xlen-1:0] imm_s,
  output logic [rv_core_pkg::xlen-1:0] imm_b,
  output logic [rv_core_pkg::xlen-1:0] imm_u,
  output logic [rv_core_pkg::xlen-1:0] imm_j,
  output logic [5:0]                   shamt
);

  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [5:0] funct6;

  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  // rv64 shifts take a 6-bit shamt, so only the top six bits are funct
  assign funct6 = inst[31:26];

  assign rd    = inst[11:7];
  assign rs1   = inst[19:15];
  assign rs2   = inst[24:20];
  assign shamt = inst[25:20];

  assign imm_i = {{(xlen-12){inst[31]}}, inst[31:20]};
  assign imm_s = {{(xlen-12){inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{(xlen-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{(xlen-32){inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{(xlen-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    op = op_illegal;
    case (inst[6:0])
      op_reg: begin
        case ({funct7, funct3})
          10'b0000000_000: op = op_i_add;
          10'b0100000_000: op = op_i_sub;
          10'b0000000_111: op = op_i_and;
          10'b0000000_110: op = op_i_or;
          10'b0000000_100: op = op_i_xor;
          10'b0000000_001: op = op_i_sll;
          10'b0000000_101: op = op_i_srl;
          10'b0100000_101: op = op_i_sra;
          10'b0000000_010: op = op_i_slt;
          10'b0000000_011: op = op_i_sltu;
          default:         op = op_illegal;
        endcase
      end
      op_imm: begin
        case (funct3)
          3'b000: op = op_i_addi;
          3'b111: op = op_i_andi;
          3'b110: op = op_i_ori;
          3'b100: op = op_i_xori;
          3'b010: op = op_i_slti;
          3'b011: op = op_i_sltiu;
          3'b001: op = (funct6 == 6'b000000) ? op_i_slli : op_illegal;
          default: begin
            if (funct6 == 6'b000000)
              op = op_i_srli;
            else if (funct6 == 6'b010000)
              op = op_i_srai;
          end
        endcase
      end
      op_imm_32: op = (funct3 == 3'b000) ? op_i_addiw : op_illegal;
      op_reg_32: begin
        case ({funct7, funct3})
          10'b0000000_000: op = op_i_addw;
          10'b0100000_000: op = op_i_subw;
          10'b0000000_001: op = op_i_sllw;
          default:         op = op_illegal;
        endcase
      end
      op_lui:   op = op_i_lui;
      op_auipc: op = op_i_auipc;
      op_jal:   op = op_i_jal;
      op_jalr:  op = (funct3 == 3'b000) ? op_i_jalr : op_illegal;
      op_branch: begin
        case (funct3)
          3'b000:  op = op_i_beq;
          3'b001:  op = op_i_bne;
          3'b100:  op = op_i_blt;
          3'b101:  op = op_i_bge;
          default: op = op_illegal;
        endcase
      end
      op_load: begin
        case (funct3)
          3'b000:  op = op_i_lb;
          3'b100:  op = op_i_lbu;
          3'b010:  op = op_i_lw;
          3'b011:  op = op_i_ld;
          default: op = op_illegal;
        endcase
      end
      op_store: begin
        case (funct3)
          3'b000:  op = op_i_sb;
          3'b001:  op = op_i_sh;
          3'b010:  op = op_i_sw;
          3'b011:  op = op_i_sd;
          default: op = op_illegal;
        endcase
      end
      op_system: op = (inst[31:7] == 25'h0002000) ? op_i_ebreak : op_illegal;
      default:   op = op_illegal;
    endcase
  end

endmodule

/* verilog/rv_isa_pkg.sv */
package rv_isa_pkg;

  // major opcodes in inst[6:0]
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_imm_32 = 7'b0011011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_reg_32 = 7'b0111011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_system = 7'b1110011;

  // one entry per decoded instruction
  typedef enum logic [5:0] {
    op_illegal,
    op_i_add, op_i_sub, op_i_and, op_i_or, op_i_xor,
    op_i_sll, op_i_srl, op_i_sra, op_i_slt, op_i_sltu,
    op_i_addi, op_i_andi, op_i_ori, op_i_xori, op_i_slti,
    op_i_sltiu, op_i_slli, op_i_srli, op_i_srai,
    op_i_addw, op_i_subw, op_i_addiw, op_i_sllw,
    op_i_lui, op_i_auipc, op_i_jal, op_i_jalr,
    op_i_beq, op_i_bne, op_i_blt, op_i_bge,
    op_i_lb, op_i_lbu, op_i_lw, op_i_ld,
    op_i_sb, op_i_sh, op_i_sw, op_i_sd,
    op_i_ebreak
  } op_e;

endpackage

/* verilog/rv_lsu.sv */
`timescale 1ns/1ps

module rv_lsu #(
  parameter int dmem_words = 256
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  rv_isa_pkg::op_e              op,
  input  logic                         wen,
  input  logic [rv_core_pkg::xlen-1:0] addr,
  input  logic [rv_core_pkg::xlen-1:0] store_data,
  output logic [rv_core_pkg::xlen-1:0] load_data
);

  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  localparam int aw = $clog2(dmem_words);

  logic [xlen-1:0] mem [dmem_words];

  logic [aw-1:0]   idx;
  logic [2:0]      offset;
  logic [7:0]      byte_mask;
  logic [xlen-1:0] lane_data;
  logic [xlen-1:0] word;
  logic [xlen-1:0] shifted;

  // upper address bits beyond the array wrap around
  assign idx    = addr[aw+2:3];
  assign offset = addr[2:0];

  always_comb begin
    case (op)
      op_i_sb: byte_mask = 8'h01 << offset;
      op_i_sh: byte_mask = 8'h03 << offset;
      op_i_sw: byte_mask = 8'h0f << offset;
      op_i_sd: byte_mask = 8'hff;
      default: byte_mask = 8'h00;
    endcase
  end

  assign lane_data = store_data << {offset, 3'b000};

  always_ff @(posedge clk) begin
    if (rst_n && wen) begin
      for (int i = 0; i < 8; i++) begin
        if (byte_mask[i]) begin
          mem[idx][8*i +: 8] <= lane_data[8*i +: 8];
        end
      end
    end
  end

  assign word    = mem[idx];
  assign shifted = word >> {offset, 3'b000};

  always_comb begin
    case (op)
      op_i_lb:  load_data = {{(xlen-8){shifted[7]}}, shifted[7:0]};
      op_i_lbu: load_data = {{(xlen-8){1'b0}}, shifted[7:0]};
      op_i_lw:  load_data = {{(xlen-32){shifted[31]}}, shifted[31:0]};
      op_i_ld:  load_data = word;
      default:  load_data = '0;
    endcase
  end

endmodule

/* verilog/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
  input  logic                         clk,
  input  logic                         wen,
  input  logic [4:0]                   waddr,
  input  logic [rv_core_pkg::xlen-1:0] wdata,
  input  logic [4:0]                   raddr_a,
  input  logic [4:0]                   raddr_b,
  output logic [rv_core_pkg::xlen-1:0] rdata_a,
  output logic [rv_core_pkg::xlen-1:0] rdata_b
);

  import rv_core_pkg::*;

  // entry 0 is never written and reads of x0 are forced to zero
  logic [xlen-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (wen && (waddr != 5'd0)) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata_a = (raddr_a == 5'd0) ? '0 : regs[raddr_a];
  assign rdata_b = (raddr_b == 5'd0) ? '0 : regs[raddr_b];

endmodule
